/* rtl/frontend_pkg.sv */
package frontend_pkg;

    // Bundle geometry
    localparam int INSTR_W  = 32;               // POWER instructions are fixed size
    localparam int LANES    = 4;                // Decoder lanes, also max instructions per bundle
    localparam int BUNDLE_W = LANES * INSTR_W;
    localparam int ADDR_W   = 64;
    localparam int MAJ_ID_W = 16;
    localparam int LEN_W    = 2;                // Instruction count minus one
    localparam int REG_W    = 5;                // GPR number

    // Primary opcodes, instruction bits 0 to 5
    localparam logic [0:5] OPC_ADDI  = 6'd14;
    localparam logic [0:5] OPC_ADDIS = 6'd15;
    localparam logic [0:5] OPC_BC    = 6'd16;
    localparam logic [0:5] OPC_B     = 6'd18;
    localparam logic [0:5] OPC_XFORM = 6'd31;   // Extended opcode follows
    localparam logic [0:5] OPC_LWZ   = 6'd32;
    localparam logic [0:5] OPC_STW   = 6'd36;

    // Extended opcodes for the X/XO form, bits 21 to 30
    localparam logic [0:9] XO_ADD  = 10'd266;
    localparam logic [0:9] XO_SUBF = 10'd40;
    localparam logic [0:9] XO_AND  = 10'd28;
    localparam logic [0:9] XO_OR   = 10'd444;

    // Decoded operation classes
    typedef enum logic [3:0] {
        OP_ADDI,
        OP_ADDIS,
        OP_ADD,
        OP_SUBF,
        OP_AND,
        OP_OR,
        OP_LOAD,         // lwz
        OP_STORE,        // stw
        OP_BRANCH,       // Unconditional, imm carries raw LI low half
        OP_BRANCH_COND,
        OP_ILLEGAL       // Anything outside the supported subset
    } op_class_t;

endpackage

/* rtl/bundle_receiver.sv */
`timescale 1ns/1ns

module bundle_receiver import frontend_pkg::*; (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic                bundle_req_i,
    input  logic [0:BUNDLE_W-1] bundle_i,
    input  logic [0:ADDR_W-1]   bundle_addr_i,
    input  logic [0:LEN_W-1]    bundle_len_i,
    input  logic                is64_i,
    input  logic                held_take_i,
    output logic                bundle_ack_o,
    output logic                held_valid_o,
    output logic [0:BUNDLE_W-1] held_bundle_o,
    output logic [0:ADDR_W-1]   held_addr_o,
    output logic [0:LEN_W-1]    held_len_o,
    output logic                held_is64_o,
    output logic [0:MAJ_ID_W-1] held_maj_id_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_ACK,
        RX_WAIT_LOW
    } rx_state_t;

    rx_state_t state_q;
    logic      capture;

    // Only take a new bundle into an empty holding register
    assign capture      = (state_q == RX_IDLE) && bundle_req_i && !held_valid_o;
    assign bundle_ack_o = (state_q != RX_IDLE);

    // Four-phase slave
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q <= RX_IDLE;
        end else begin
            case (state_q)
                RX_IDLE: begin
                    if (capture) state_q <= RX_ACK;
                end
                RX_ACK: begin
                    state_q <= bundle_req_i ? RX_WAIT_LOW : RX_IDLE;
                end
                RX_WAIT_LOW: begin
                    if (!bundle_req_i) state_q <= RX_IDLE; // Ack drops next cycle
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Holding register state and running major ID
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            held_valid_o  <= 1'b0;
            held_maj_id_o <= '0;
        end else if (capture) begin
            held_valid_o <= 1'b1;
        end else if (held_take_i) begin
            held_valid_o  <= 1'b0;
            // Skip over every instruction of the bundle just taken
            held_maj_id_o <= held_maj_id_o + MAJ_ID_W'(held_len_o) + 1'b1;
        end
    end

    always_ff @(posedge clock_i) begin
        if (capture) begin
            held_bundle_o <= bundle_i;
            held_addr_o   <= bundle_addr_i;
            held_len_o    <= bundle_len_i;
            held_is64_o   <= is64_i;
        end
    end

    // Parser must not release a register that holds nothing
    a_take_needs_valid: assert property (
        @(posedge clock_i) disable iff (reset_i) held_take_i |-> held_valid_o
    );

endmodule

/* rtl/bundle_parser.sv */
`timescale 1ns/1ns

module bundle_parser import frontend_pkg::*; (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic                held_valid_i,
    input  logic [0:BUNDLE_W-1] held_bundle_i,
    input  logic [0:ADDR_W-1]   held_addr_i,
    input  logic [0:LEN_W-1]    held_len_i,
    input  logic                held_is64_i,
    input  logic [0:MAJ_ID_W-1] held_maj_id_i,
    input  logic [0:LANES-1]    lane_free_i,
    output logic                held_take_o,
    output logic [0:LANES-1]    lane_load_o,
    output logic [0:INSTR_W-1]  lane0_instr_o,
    output logic [0:INSTR_W-1]  lane1_instr_o,
    output logic [0:INSTR_W-1]  lane2_instr_o,
    output logic [0:INSTR_W-1]  lane3_instr_o,
    output logic [0:ADDR_W-1]   lane_base_addr_o,
    output logic [0:MAJ_ID_W-1] lane_maj_id_o,
    output logic                lane_is64_o
);

    logic [0:LANES-1] therm;

    // A bundle moves on only when every lane has drained
    assign held_take_o = held_valid_i && (&lane_free_i);

    // Lane enables from the length code, lane 0 in bit 0
    always_comb begin
        case (held_len_i)
            2'd0:    therm = 4'b1000;  // One instruction
            2'd1:    therm = 4'b1100;
            2'd2:    therm = 4'b1110;
            default: therm = 4'b1111;  // Full bundle
        endcase
    end

    assign lane_load_o = held_take_o ? therm : '0;

    // Instruction 0 sits in the most significant word
    assign lane0_instr_o = held_bundle_i[0 * INSTR_W +: INSTR_W];
    assign lane1_instr_o = held_bundle_i[1 * INSTR_W +: INSTR_W];
    assign lane2_instr_o = held_bundle_i[2 * INSTR_W +: INSTR_W];
    assign lane3_instr_o = held_bundle_i[3 * INSTR_W +: INSTR_W];

    // Per-lane offsets are added in each decoder
    assign lane_base_addr_o = held_addr_i;
    assign lane_maj_id_o    = held_maj_id_i;
    assign lane_is64_o      = held_is64_i;

    a_load_thermometer: assert property (
        @(posedge clock_i) disable iff (reset_i)
        lane_load_o inside {4'b0000, 4'b1000, 4'b1100, 4'b1110, 4'b1111}
    );

    // Never overwrite a lane the sequencer has not popped yet
    a_load_only_free: assert property (
        @(posedge clock_i) disable iff (reset_i) (lane_load_o & ~lane_free_i) == '0
    );

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder import frontend_pkg::*; #(
    parameter int LANE = 0
) (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic                load_i,
    input  logic [0:INSTR_W-1]  instr_i,
    input  logic [0:ADDR_W-1]   base_addr_i,
    input  logic [0:MAJ_ID_W-1] base_maj_id_i,
    input  logic                is64_i,
    input  logic                pop_i,
    output logic                free_o,
    output logic                valid_o,
    output op_class_t           op_o,
    output logic [0:REG_W-1]    rt_o,
    output logic [0:REG_W-1]    ra_o,
    output logic [0:REG_W-1]    rb_o,
    output logic [0:15]         imm_o,
    output logic [0:ADDR_W-1]   addr_o,
    output logic [0:MAJ_ID_W-1] maj_id_o,
    output logic                is64_o
);

    logic [0:5] opcode;
    logic [0:9] xo;
    op_class_t  op_d;

    assign opcode = instr_i[0:5];
    assign xo     = instr_i[21:30];

    // Classify the small supported subset
    always_comb begin
        case (opcode)
            OPC_ADDI:  op_d = OP_ADDI;
            OPC_ADDIS: op_d = OP_ADDIS;
            OPC_BC:    op_d = OP_BRANCH_COND;
            OPC_B:     op_d = OP_BRANCH;
            OPC_LWZ:   op_d = OP_LOAD;
            OPC_STW:   op_d = OP_STORE;
            OPC_XFORM: begin
                case (xo)
                    XO_ADD:  op_d = OP_ADD;
                    XO_SUBF: op_d = OP_SUBF;
                    XO_AND:  op_d = OP_AND;
                    XO_OR:   op_d = OP_OR;
                    default: op_d = OP_ILLEGAL;
                endcase
            end
            default:   op_d = OP_ILLEGAL;
        endcase
    end

    // Slot occupancy
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= 1'b1;
        end else if (pop_i) begin
            valid_o <= 1'b0;
        end
    end

    assign free_o = !valid_o;

    // Decoded fields, captured with the instruction
    always_ff @(posedge clock_i) begin
        if (load_i) begin
            op_o     <= op_d;
            rt_o     <= instr_i[6:10];
            ra_o     <= instr_i[11:15];
            rb_o     <= instr_i[16:20];
            imm_o    <= instr_i[16:31];  // Raw low half, also for branches
            addr_o   <= base_addr_i + ADDR_W'(4 * LANE);
            maj_id_o <= base_maj_id_i + MAJ_ID_W'(LANE);
            is64_o   <= is64_i;
        end
    end

    // Parser only loads free lanes, sequencer only pops full ones
    a_no_load_and_pop: assert property (
        @(posedge clock_i) disable iff (reset_i) !(load_i && pop_i)
    );

endmodule

/* rtl/decode_sequencer.sv */
`timescale 1ns/1ns

module decode_sequencer import frontend_pkg::*; (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic [0:LANES-1]    dec_valid_i,
    input  op_class_t           dec_op_i     [0:LANES-1],
    input  logic [0:REG_W-1]    dec_rt_i     [0:LANES-1],
    input  logic [0:REG_W-1]    dec_ra_i     [0:LANES-1],
    input  logic [0:REG_W-1]    dec_rb_i     [0:LANES-1],
    input  logic [0:15]         dec_imm_i    [0:LANES-1],
    input  logic [0:ADDR_W-1]   dec_addr_i   [0:LANES-1],
    input  logic [0:MAJ_ID_W-1] dec_maj_id_i [0:LANES-1],
    input  logic [0:LANES-1]    dec_is64_i,
    input  logic                op_ack_i,
    output logic [0:LANES-1]    dec_pop_o,
    output logic                op_req_o,
    output op_class_t           op_class_o,
    output logic [0:REG_W-1]    op_rt_o,
    output logic [0:REG_W-1]    op_ra_o,
    output logic [0:REG_W-1]    op_rb_o,
    output logic [0:15]         op_imm_o,
    output logic [0:ADDR_W-1]   op_addr_o,
    output logic [0:MAJ_ID_W-1] op_maj_id_o,
    output logic                op_is64_o
);

    typedef enum logic [1:0] {
        SQ_WAIT,
        SQ_REQ,
        SQ_WAIT_LOW
    } sq_state_t;

    sq_state_t                state_q;
    logic [$clog2(LANES)-1:0] ptr_q;
    logic                     pop_q;
    logic                     last_q;   // Pointed lane closes its bundle
    logic                     start;

    assign start = (state_q == SQ_WAIT) && dec_valid_i[ptr_q];

    // Lanes of one bundle are all still full when the first one starts, so the
    // successor check here cannot see a lane from the next bundle
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q  <= SQ_WAIT;
            ptr_q    <= '0;
            pop_q    <= 1'b0;
            last_q   <= 1'b0;
            op_req_o <= 1'b0;
        end else begin
            pop_q <= 1'b0;
            case (state_q)
                SQ_WAIT: begin
                    if (start) begin
                        op_req_o <= 1'b1;
                        pop_q    <= 1'b1;
                        last_q   <= (int'(ptr_q) == LANES - 1) || !dec_valid_i[ptr_q + 1'b1];
                        state_q  <= SQ_REQ;
                    end
                end
                SQ_REQ: begin
                    if (op_ack_i) begin
                        op_req_o <= 1'b0;
                        state_q  <= SQ_WAIT_LOW;
                    end
                end
                SQ_WAIT_LOW: begin
                    if (!op_ack_i) begin
                        ptr_q   <= last_q ? '0 : ptr_q + 1'b1;
                        state_q <= SQ_WAIT;
                    end
                end
                default: state_q <= SQ_WAIT;
            endcase
        end
    end

    // One-cycle pop, same cycle as the rising req
    always_comb begin
        dec_pop_o = '0;
        if (pop_q) dec_pop_o[ptr_q] = 1'b1;
    end

    always_ff @(posedge clock_i) begin
        if (start) begin
            op_class_o  <= dec_op_i[ptr_q];
            op_rt_o     <= dec_rt_i[ptr_q];
            op_ra_o     <= dec_ra_i[ptr_q];
            op_rb_o     <= dec_rb_i[ptr_q];
            op_imm_o    <= dec_imm_i[ptr_q];
            op_addr_o   <= dec_addr_i[ptr_q];
            op_maj_id_o <= dec_maj_id_i[ptr_q];
            op_is64_o   <= dec_is64_i[ptr_q];
        end
    end

    a_req_held_until_ack: assert property (
        @(posedge clock_i) disable iff (reset_i) $fell(op_req_o) |-> $past(op_ack_i)
    );

endmodule

/* rtl/decode_frontend.sv */
`timescale 1ns/1ns

module decode_frontend import frontend_pkg::*; (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic                bundle_req_i,
    input  logic [0:BUNDLE_W-1] bundle_i,
    input  logic [0:ADDR_W-1]   bundle_addr_i,
    input  logic [0:LEN_W-1]    bundle_len_i,
    input  logic                is64_i,
    output logic                bundle_ack_o,
    output logic                op_req_o,
    output op_class_t           op_class_o,
    output logic [0:REG_W-1]    op_rt_o,
    output logic [0:REG_W-1]    op_ra_o,
    output logic [0:REG_W-1]    op_rb_o,
    output logic [0:15]         op_imm_o,
    output logic [0:ADDR_W-1]   op_addr_o,
    output logic [0:MAJ_ID_W-1] op_maj_id_o,
    output logic                op_is64_o,
    input  logic                op_ack_i
);

    // Receiver to parser
    logic                held_valid;
    logic [0:BUNDLE_W-1] held_bundle;
    logic [0:ADDR_W-1]   held_addr;
    logic [0:LEN_W-1]    held_len;
    logic                held_is64;
    logic [0:MAJ_ID_W-1] held_maj_id;
    logic                held_take;

    // Parser to lanes
    logic [0:LANES-1]    lane_load;
    logic [0:LANES-1]    lane_free;
    logic [0:INSTR_W-1]  lane_instr [0:LANES-1];
    logic [0:ADDR_W-1]   lane_base_addr;
    logic [0:MAJ_ID_W-1] lane_maj_id;
    logic                lane_is64;

    // Lanes to sequencer
    logic [0:LANES-1]    dec_valid;
    logic [0:LANES-1]    dec_pop;
    op_class_t           dec_op     [0:LANES-1];
    logic [0:REG_W-1]    dec_rt     [0:LANES-1];
    logic [0:REG_W-1]    dec_ra     [0:LANES-1];
    logic [0:REG_W-1]    dec_rb     [0:LANES-1];
    logic [0:15]         dec_imm    [0:LANES-1];
    logic [0:ADDR_W-1]   dec_addr   [0:LANES-1];
    logic [0:MAJ_ID_W-1] dec_maj_id [0:LANES-1];
    logic [0:LANES-1]    dec_is64;

    bundle_receiver bundle_receiver_i (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .bundle_req_i  (bundle_req_i),
        .bundle_i      (bundle_i),
        .bundle_addr_i (bundle_addr_i),
        .bundle_len_i  (bundle_len_i),
        .is64_i        (is64_i),
        .held_take_i   (held_take),
        .bundle_ack_o  (bundle_ack_o),
        .held_valid_o  (held_valid),
        .held_bundle_o (held_bundle),
        .held_addr_o   (held_addr),
        .held_len_o    (held_len),
        .held_is64_o   (held_is64),
        .held_maj_id_o (held_maj_id)
    );

    bundle_parser bundle_parser_i (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .held_valid_i     (held_valid),
        .held_bundle_i    (held_bundle),
        .held_addr_i      (held_addr),
        .held_len_i       (held_len),
        .held_is64_i      (held_is64),
        .held_maj_id_i    (held_maj_id),
        .lane_free_i      (lane_free),
        .held_take_o      (held_take),
        .lane_load_o      (lane_load),
        .lane0_instr_o    (lane_instr[0]),
        .lane1_instr_o    (lane_instr[1]),
        .lane2_instr_o    (lane_instr[2]),
        .lane3_instr_o    (lane_instr[3]),
        .lane_base_addr_o (lane_base_addr),
        .lane_maj_id_o    (lane_maj_id),
        .lane_is64_o      (lane_is64)
    );

    // One decoder per lane, lane index sets address and ID offset
    for (genvar n = 0; n < LANES; n++) begin : g_lane
        instr_decoder #(.LANE(n)) instr_decoder_i (
            .clock_i       (clock_i),
            .reset_i       (reset_i),
            .load_i        (lane_load[n]),
            .instr_i       (lane_instr[n]),
            .base_addr_i   (lane_base_addr),
            .base_maj_id_i (lane_maj_id),
            .is64_i        (lane_is64),
            .pop_i         (dec_pop[n]),
            .free_o        (lane_free[n]),
            .valid_o       (dec_valid[n]),
            .op_o          (dec_op[n]),
            .rt_o          (dec_rt[n]),
            .ra_o          (dec_ra[n]),
            .rb_o          (dec_rb[n]),
            .imm_o         (dec_imm[n]),
            .addr_o        (dec_addr[n]),
            .maj_id_o      (dec_maj_id[n]),
            .is64_o        (dec_is64[n])
        );
    end

    decode_sequencer decode_sequencer_i (
        .clock_i      (clock_i),
        .reset_i      (reset_i),
        .dec_valid_i  (dec_valid),
        .dec_op_i     (dec_op),
        .dec_rt_i     (dec_rt),
        .dec_ra_i     (dec_ra),
        .dec_rb_i     (dec_rb),
        .dec_imm_i    (dec_imm),
        .dec_addr_i   (dec_addr),
        .dec_maj_id_i (dec_maj_id),
        .dec_is64_i   (dec_is64),
        .op_ack_i     (op_ack_i),
        .dec_pop_o    (dec_pop),
        .op_req_o     (op_req_o),
        .op_class_o   (op_class_o),
        .op_rt_o      (op_rt_o),
        .op_ra_o      (op_ra_o),
        .op_rb_o      (op_rb_o),
        .op_imm_o     (op_imm_o),
        .op_addr_o    (op_addr_o),
        .op_maj_id_o  (op_maj_id_o),
        .op_is64_o    (op_is64_o)
    );

endmodule

/* verif/tb_decode_frontend.sv */
`timescale 1ns/1ns

module tb_decode_frontend import frontend_pkg::*; ();

    localparam int TIMEOUT      = 1000;  // Cycles per wait
    localparam int STALL_CYCLES = 12;    // Ack wait that counts as back-pressure
    localparam int IDLE_CYCLES  = 20;    // Quiet cycles after the last operation
    localparam int N_RANDOM     = 40;
    localparam int N_SLOW       = 10;

    // Primary and extended opcode per form with the last three illegal
    localparam int N_FORMS = 13;
    localparam int FORM_OPC [N_FORMS] = '{14, 15, 16, 18, 32, 36, 31, 31, 31, 31, 0, 63, 31};
    localparam int FORM_XO  [N_FORMS] = '{0, 0, 0, 0, 0, 0, 266, 40, 28, 444, 0, 0, 999};

    typedef struct packed {
        op_class_t   cls;
        logic [4:0]  rt;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [15:0] imm;
        logic [63:0] addr;
        logic [15:0] maj_id;
        logic        is64;
    } exp_op_t;

    logic                clock_i;
    logic                reset_i;
    logic                bundle_req_i;
    logic [0:BUNDLE_W-1] bundle_i;
    logic [0:ADDR_W-1]   bundle_addr_i;
    logic [0:LEN_W-1]    bundle_len_i;
    logic                is64_i;
    logic                bundle_ack_o;
    logic                op_req_o;
    op_class_t           op_class_o;
    logic [0:REG_W-1]    op_rt_o;
    logic [0:REG_W-1]    op_ra_o;
    logic [0:REG_W-1]    op_rb_o;
    logic [0:15]         op_imm_o;
    logic [0:ADDR_W-1]   op_addr_o;
    logic [0:MAJ_ID_W-1] op_maj_id_o;
    logic                op_is64_o;
    logic                op_ack_i;

    exp_op_t     exp_q[$];
    logic [15:0] exp_maj;     // Next major ID the DUT should hand out
    int          ops_seen;
    logic        slow_sink;
    logic        driver_done;
    logic        stall_seen;

    decode_frontend decode_frontend_i (.*);

    initial begin
        clock_i = 1'b0;
        forever #4 clock_i = ~clock_i;
    end

    task automatic step_cycle();
        @(posedge clock_i);
        #1;  // Drive and sample away from the edge
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Mismatch in %s: expected 0x%0h, actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    // Expected decode of one instruction from the POWER field layout
    function automatic exp_op_t ref_decode(input logic [0:31] w, input logic [63:0] addr,
                                           input logic [15:0] maj_id, input logic is64);
        exp_op_t e;
        int      opc;
        int      xo;
        opc = int'(w[0:5]);
        xo  = int'(w[21:30]);
        case (opc)
            14: e.cls = OP_ADDI;
            15: e.cls = OP_ADDIS;
            16: e.cls = OP_BRANCH_COND;
            18: e.cls = OP_BRANCH;
            32: e.cls = OP_LOAD;
            36: e.cls = OP_STORE;
            31: begin
                if (xo == 266)      e.cls = OP_ADD;
                else if (xo == 40)  e.cls = OP_SUBF;
                else if (xo == 28)  e.cls = OP_AND;
                else if (xo == 444) e.cls = OP_OR;
                else                e.cls = OP_ILLEGAL;
            end
            default: e.cls = OP_ILLEGAL;
        endcase
        e.rt     = w[6:10];
        e.ra     = w[11:15];
        e.rb     = w[16:20];
        e.imm    = w[16:31];
        e.addr   = addr;
        e.maj_id = maj_id;
        e.is64   = is64;
        return e;
    endfunction

    function automatic logic [0:31] make_instr();
        logic [0:31] w;
        int          k;
        w = $urandom;           // Random registers and immediate
        k = $urandom_range(0, N_FORMS - 1);
        w[0:5] = 6'(FORM_OPC[k]);
        if (FORM_OPC[k] == 31) w[21:30] = 10'(FORM_XO[k]);
        return w;
    endfunction

    task automatic drive_bundle(input int len);
        logic [0:BUNDLE_W-1] bundle;
        logic [63:0]         addr;
        logic [0:31]         w;
        logic                is64;
        int                  cycles;
        addr       = {$urandom, $urandom};
        addr[1:0]  = 2'b00;
        is64       = 1'($urandom_range(0, 1));
        for (int n = 0; n < LANES; n++) begin
            w = make_instr();   // Unused lanes carry junk
            bundle[n * INSTR_W +: INSTR_W] = w;
            if (n <= len) begin
                exp_q.push_back(ref_decode(w, addr + 64'(4 * n), exp_maj + 16'(n), is64));
            end
        end
        cycles = 0;
        while (bundle_ack_o) begin   // New req only with ack low
            cycles++;
            if (cycles > TIMEOUT) abort_run("Timeout: bundle_ack_o stuck high before request");
            step_cycle();
        end
        bundle_req_i  = 1'b1;
        bundle_i      = bundle;
        bundle_addr_i = addr;
        bundle_len_i  = 2'(len);
        is64_i        = is64;
        cycles = 0;
        step_cycle();
        while (!bundle_ack_o) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("Timeout: bundle_ack_o never rose for a bundle");
            step_cycle();
        end
        if (cycles > STALL_CYCLES) stall_seen = 1'b1;
        bundle_req_i = 1'b0;
        exp_maj  = exp_maj + 16'(len + 1);
        cycles = 0;
        step_cycle();
        while (bundle_ack_o) begin
            cycles++;
            if (cycles > TIMEOUT) abort_run("Timeout: bundle_ack_o did not fall after req");
            step_cycle();
        end
    endtask

    task automatic compare_op(input exp_op_t e, input int idx);
        check_value($sformatf("op %0d class", idx), 64'(e.cls), 64'(op_class_o));
        check_value($sformatf("op %0d rt", idx), 64'(e.rt), 64'(op_rt_o));
        check_value($sformatf("op %0d ra", idx), 64'(e.ra), 64'(op_ra_o));
        check_value($sformatf("op %0d rb", idx), 64'(e.rb), 64'(op_rb_o));
        check_value($sformatf("op %0d imm", idx), 64'(e.imm), 64'(op_imm_o));
        check_value($sformatf("op %0d addr", idx), e.addr, op_addr_o);
        check_value($sformatf("op %0d maj_id", idx), 64'(e.maj_id), 64'(op_maj_id_o));
        check_value($sformatf("op %0d is64", idx), 64'(e.is64), 64'(op_is64_o));
    endtask

    // Sink side of the output four-phase port
    task automatic monitor_ops();
        exp_op_t e;
        int      cycles;
        int      delay;
        while (!driver_done || exp_q.size() > 0) begin
            cycles = 0;
            while (!op_req_o) begin
                cycles++;
                if (cycles > TIMEOUT) abort_run("Timeout: no op_req_o for a pending operation");
                step_cycle();
            end
            if (exp_q.size() == 0) abort_run("op_req_o raised with no operation expected");
            e = exp_q.pop_front();
            compare_op(e, ops_seen);
            delay = slow_sink ? 5 : $urandom_range(0, 5);
            repeat (delay) begin
                step_cycle();
                check_value($sformatf("op %0d req held", ops_seen), 64'd1, 64'(op_req_o));
                check_value($sformatf("op %0d maj_id stable", ops_seen),
                            64'(e.maj_id), 64'(op_maj_id_o));
            end
            op_ack_i = 1'b1;
            cycles = 0;
            step_cycle();
            while (op_req_o) begin
                cycles++;
                if (cycles > TIMEOUT) abort_run("Timeout: op_req_o stayed high after ack");
                step_cycle();
            end
            op_ack_i = 1'b0;
            step_cycle();
            check_value($sformatf("op %0d req low after ack drop", ops_seen), 64'd0,
                        64'(op_req_o));
            ops_seen++;
        end
    endtask

    initial begin
        void'($urandom(18142));
        reset_i       = 1'b1;
        bundle_req_i  = 1'b0;
        bundle_i      = '0;
        bundle_addr_i = '0;
        bundle_len_i  = '0;
        is64_i        = 1'b0;
        op_ack_i      = 1'b0;
        exp_maj       = '0;
        ops_seen      = 0;
        slow_sink     = 1'b0;
        driver_done   = 1'b0;
        stall_seen    = 1'b0;
        repeat (10) @(posedge clock_i);
        #1 reset_i = 1'b0;
        check_value("reset op_req_o", 64'd0, 64'(op_req_o));
        check_value("reset bundle_ack_o", 64'd0, 64'(bundle_ack_o));
        fork
            begin
                for (int b = 0; b < N_RANDOM; b++) drive_bundle($urandom_range(0, 3));
                slow_sink = 1'b1;  // Full bundles into a slow sink
                for (int b = 0; b < N_SLOW; b++) drive_bundle(3);
                driver_done = 1'b1;
            end
            monitor_ops();
        join
        // Every expected operation is out, nothing further may be offered
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            step_cycle();
            check_value("no extra operation", 64'd0, 64'(op_req_o));
        end
        check_value("input back-pressure", 64'd1, 64'(stall_seen));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* compile.f */
rtl/frontend_pkg.sv
rtl/bundle_receiver.sv
rtl/bundle_parser.sv
rtl/instr_decoder.sv
rtl/decode_sequencer.sv
rtl/decode_frontend.sv
verif/tb_decode_frontend.sv

/* run.sh */
#!/bin/sh
# Build the decode front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_decode_frontend -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_decode_frontend; then
    echo "Testbench run returned a failing status"
    exit 1
fi

exit 0
